/* design/bus_xfer.sv */
// mapper-owned bus transfer with BR/BG/BGACK arbitration and board bus mux
`timescale 1ns/1ps
`include "mapper_config.svh"

module bus_xfer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_cen,
    input  logic                   xfer_start,
    input  mapper_pkg::xfer_cmd_e  xfer_cmd,
    input  logic [23:1]            rd_addr,
    input  logic [23:1]            wr_addr,
    input  logic [15:0]            wr_data,
    input  logic [23:1]            addr,
    input  logic [15:0]            cpu_dout,
    input  logic [1:0]             cpu_dsn,
    input  logic                   cpu_asn,
    input  logic                   cpu_rnw,
    input  logic                   cpu_bgn,
    input  logic                   bus_busy,
    output logic                   cpu_brn,
    output logic                   cpu_bgackn,
    output logic [23:1]            addr_out,
    output logic [15:0]            bus_din,
    output logic                   bus_asn,
    output logic [1:0]             bus_dsn,
    output logic                   bus_rnw,
    output logic                   xfer_busy,
    output logic                   rd_done
);

    localparam int HW = $clog2(`MAP_XFER_HOLD);

    mapper_pkg::xfer_state_e state;
    logic [HW-1:0]           hold_cnt;
    logic                    is_read;   // latched at start
    logic                    own_bus;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= mapper_pkg::XS_IDLE;
            cpu_brn    <= 1'b1;
            cpu_bgackn <= 1'b1;
            rd_done    <= 1'b0;
            is_read    <= 1'b0;
            hold_cnt   <= '0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                mapper_pkg::XS_IDLE: if (xfer_start) begin
                    is_read <= xfer_cmd == mapper_pkg::XFER_READ;
                    state   <= mapper_pkg::XS_REQUEST;
                end
                mapper_pkg::XS_REQUEST: if (cpu_cen) begin
                    cpu_brn <= 1'b0;
                    state   <= mapper_pkg::XS_WAIT_IDLE;
                end
                mapper_pkg::XS_WAIT_IDLE: if (!cpu_bgn && cpu_asn) begin   // CPU let go
                    cpu_bgackn <= 1'b0;
                    cpu_brn    <= 1'b1;
                    hold_cnt   <= '0;
                    state      <= mapper_pkg::XS_OWN;
                end
                mapper_pkg::XS_OWN: begin
                    if (hold_cnt != HW'(`MAP_XFER_HOLD-1)) begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end else if (!bus_busy) begin
                        rd_done <= is_read;
                        state   <= mapper_pkg::XS_RELEASE;
                    end
                end
                default: begin   // release, hand the bus back
                    cpu_bgackn <= 1'b1;
                    state      <= mapper_pkg::XS_IDLE;
                end
            endcase
        end
    end

    assign xfer_busy = state != mapper_pkg::XS_IDLE;
    assign own_bus   = state == mapper_pkg::XS_OWN || state == mapper_pkg::XS_RELEASE;

    assign addr_out = own_bus ? (is_read ? rd_addr : wr_addr) : addr;
    assign bus_din  = own_bus ? wr_data : cpu_dout;
    assign bus_asn  = own_bus ? state != mapper_pkg::XS_OWN : cpu_asn;
    assign bus_dsn  = own_bus ? 2'b00 : cpu_dsn;
    assign bus_rnw  = own_bus ? is_read : cpu_rnw;

    a_grant_order: assert property (@(posedge clk) disable iff (rst)
        $fell(cpu_bgackn) |-> $past(!cpu_bgn));

endmodule

/* design/dtack_gen.sv */
// CPU clock-enable divider and DTACK wait-step counter
`timescale 1ns/1ps
`include "mapper_config.svh"

module dtack_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_asn,
    input  logic                     bus_busy,
    input  logic                     none,
    input  mapper_pkg::dtack_wait_e  dtack_wait,
    output logic                     cpu_cen,
    output logic                     cpu_dtackn
);

    localparam int DIV = `MAP_CEN_DIV;
    localparam int CW  = $clog2(DIV);

    logic [CW-1:0] cen_cnt;
    logic [1:0]    wait_cnt;
    logic [1:0]    need;   // cen pulses before DTACK

    always_ff @(posedge clk) begin
        if (rst) cen_cnt <= '0;
        else     cen_cnt <= cen_cnt == CW'(DIV-1) ? '0 : cen_cnt + 1'b1;
    end

    assign cpu_cen = cen_cnt == CW'(DIV-1);

    always_comb begin
        if (none) begin
            need = 2'd1;   // register or fast access
        end else begin
            case (dtack_wait)
                mapper_pkg::WAIT_2: need = 2'd2;
                mapper_pkg::WAIT_3: need = 2'd3;
                default:            need = 2'd1;   // WAIT_BUS relies on the busy hold
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cpu_asn) begin
            wait_cnt   <= 2'd0;
            cpu_dtackn <= 1'b1;
        end else if (cpu_dtackn && cpu_cen && !bus_busy) begin
            wait_cnt <= wait_cnt + 2'd1;
            if (wait_cnt + 2'd1 >= need) cpu_dtackn <= 1'b0;
        end
    end

    a_dtack_release: assert property (@(posedge clk) disable iff (rst)
        cpu_asn && !cpu_dtackn |=> cpu_dtackn);

endmodule

/* design/mapper_config.svh */
// mapper sizes and timing constants shared by the design blocks
`ifndef MAPPER_CONFIG_SVH
`define MAPPER_CONFIG_SVH

// number of 8-bit mapper registers
`define MAP_NREGS 32

// number of decoded regions, also the width of active
`define MAP_NREGIONS 8

// clk cycles per cpu_cen pulse
`define MAP_CEN_DIV 4

// minimum clk cycles with bus_asn low during a mapper transfer
`define MAP_XFER_HOLD 7

`endif

/* design/mapper_pkg.sv */
// mapper types: register indexes, transfer commands, DTACK waits, transfer states
package mapper_pkg;

    typedef enum logic [4:0] {
        REG_DATA_HI   = 5'd0,
        REG_DATA_LO   = 5'd1,
        REG_SND_LATCH = 5'd3,
        REG_IPL       = 5'd4,
        REG_XFER_CMD  = 5'd5,
        REG_RD_ADDR_H = 5'd7,
        REG_RD_ADDR_M = 5'd8,
        REG_RD_ADDR_L = 5'd9,
        REG_WR_ADDR_H = 5'd10,
        REG_WR_ADDR_M = 5'd11,
        REG_WR_ADDR_L = 5'd12,
        REG_REGION0   = 5'd16   // 16..31 are size/wait and base pairs
    } reg_idx_e;

    typedef enum logic [1:0] {
        XFER_NONE  = 2'b00,
        XFER_WRITE = 2'b01,
        XFER_READ  = 2'b10,
        XFER_RSVD  = 2'b11
    } xfer_cmd_e;

    typedef enum logic [1:0] {
        WAIT_1   = 2'b00,
        WAIT_2   = 2'b01,
        WAIT_3   = 2'b10,
        WAIT_BUS = 2'b11   // hold until bus_busy drops
    } dtack_wait_e;

    typedef enum logic [2:0] {
        XS_IDLE,
        XS_REQUEST,
        XS_WAIT_IDLE,
        XS_OWN,
        XS_RELEASE
    } xfer_state_e;

endpackage

/* design/mapper_regs.sv */
// mapper register file with sound latch, interrupt level and transfer command decode
`timescale 1ns/1ps
`include "mapper_config.svh"

module mapper_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [5:1]             addr,       // register select
    input  logic [7:0]             cpu_dout,   // low data byte
    input  logic                   cpu_dsn,    // low byte strobe
    input  logic                   cpu_asn,
    input  logic                   cpu_rnw,
    input  logic                   none,
    input  logic                   int_ack,
    input  logic                   sndmap_rd,
    input  logic                   xfer_busy,
    input  logic                   rd_done,
    input  logic [15:0]            bus_dout,
    output logic [127:0]           region_cfg,
    output logic [23:1]            rd_addr,
    output logic [23:1]            wr_addr,
    output logic [15:0]            wr_data,
    output logic                   xfer_start,
    output mapper_pkg::xfer_cmd_e  xfer_cmd,
    output logic [2:0]             cpu_ipln,
    output logic [7:0]             sndmap_dout,
    output logic                   sndmap_pbf,
    output logic [15:0]            mapper_dout
);

    localparam int FIRST_REGION = int'(mapper_pkg::REG_REGION0);

    logic [7:0] mmr [`MAP_NREGS];
    logic       wren;
    logic       wren_l;
    logic       wr_edge;
    logic       cmd_ok;

    // writes only land in unmapped space
    assign wren    = none & ~cpu_asn & ~cpu_dsn & ~cpu_rnw;
    assign wr_edge = wren & ~wren_l;   // once per bus cycle
    assign cmd_ok  = cpu_dout[1:0] == mapper_pkg::XFER_WRITE ||
                     cpu_dout[1:0] == mapper_pkg::XFER_READ;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAP_NREGS; i++) begin
                mmr[i] <= 8'd0;
            end
            mmr[mapper_pkg::REG_IPL] <= 8'd7;   // no interrupt pending
            wren_l     <= 1'b0;
            sndmap_pbf <= 1'b0;
            xfer_start <= 1'b0;
        end else begin
            wren_l     <= wren;
            xfer_start <= 1'b0;
            if (sndmap_rd) sndmap_pbf <= 1'b0;
            if (wr_edge) begin
                mmr[addr] <= cpu_dout;
                if (addr == mapper_pkg::REG_SND_LATCH) sndmap_pbf <= 1'b1;
                // commands during a running transfer are dropped
                if (addr == mapper_pkg::REG_XFER_CMD && cmd_ok && !xfer_busy) begin
                    xfer_start <= 1'b1;
                end
            end
            if (rd_done) begin
                mmr[mapper_pkg::REG_DATA_HI] <= bus_dout[15:8];
                mmr[mapper_pkg::REG_DATA_LO] <= bus_dout[7:0];
            end
            if (int_ack) mmr[mapper_pkg::REG_IPL] <= 8'd7;   // ack clears the level
        end
    end

    // region pairs: even holds wait/size, odd holds base
    generate
        for (genvar k = 0; k < 16; k++) begin : g_cfg
            assign region_cfg[8*k +: 8] = mmr[FIRST_REGION + k];
        end
    endgenerate

    assign xfer_cmd    = mapper_pkg::xfer_cmd_e'(mmr[mapper_pkg::REG_XFER_CMD][1:0]);
    assign rd_addr     = {mmr[mapper_pkg::REG_RD_ADDR_H][6:0],
                          mmr[mapper_pkg::REG_RD_ADDR_M],
                          mmr[mapper_pkg::REG_RD_ADDR_L]};
    assign wr_addr     = {mmr[mapper_pkg::REG_WR_ADDR_H][6:0],
                          mmr[mapper_pkg::REG_WR_ADDR_M],
                          mmr[mapper_pkg::REG_WR_ADDR_L]};
    assign wr_data     = {mmr[mapper_pkg::REG_DATA_HI], mmr[mapper_pkg::REG_DATA_LO]};
    assign mapper_dout = wr_data;   // same pair, read back by the CPU
    assign cpu_ipln    = mmr[mapper_pkg::REG_IPL][2:0];
    assign sndmap_dout = mmr[mapper_pkg::REG_SND_LATCH];

endmodule

/* design/region_decode.sv */
// region decoder, base/size compare with lowest-index priority and wait select
`timescale 1ns/1ps
`include "mapper_config.svh"

module region_decode (
    input  logic [23:16]                  addr_out,   // only the top byte is compared
    input  logic [2:0]                    cpu_fc,
    input  logic                          cpu_asn,
    input  logic [16*`MAP_NREGIONS-1:0]   region_cfg,
    output logic [`MAP_NREGIONS-1:0]      active,
    output logic                          none,
    output logic                          int_ack,
    output mapper_pkg::dtack_wait_e       dtack_wait
);

    logic [`MAP_NREGIONS-1:0] hit;
    logic [`MAP_NREGIONS-1:0] first;
    logic [7:0]               ctrl;
    logic [7:0]               base;

    assign int_ack = cpu_fc == 3'd7 && !cpu_asn;

    always_comb begin
        hit = '0;
        for (int i = 0; i < `MAP_NREGIONS; i++) begin
            ctrl = region_cfg[16*i +: 8];
            base = region_cfg[16*i+8 +: 8];
            case (ctrl[1:0])
                2'd0:    hit[i] = addr_out[23:16] == base;        // 64 kB
                2'd1:    hit[i] = addr_out[23:17] == base[7:1];   // 128 kB
                2'd2:    hit[i] = addr_out[23:19] == base[7:3];   // 512 kB
                default: hit[i] = addr_out[23:21] == base[7:5];   // 2 MB
            endcase
        end
    end

    assign first  = hit & (~hit + 1'b1);   // keep lowest set bit
    assign active = int_ack ? '0 : first;
    assign none   = !int_ack && hit == '0;

    always_comb begin
        dtack_wait = mapper_pkg::WAIT_1;
        for (int i = 0; i < `MAP_NREGIONS; i++) begin
            if (active[i]) dtack_wait = mapper_pkg::dtack_wait_e'(region_cfg[16*i+2 +: 2]);
        end
    end

    always_comb begin
        assert ($onehot0(active)) else $error("active is not one-hot");
    end

endmodule

/* design/sys_mapper.sv */
// memory mapper top, joins decode, DTACK, registers and bus transfer
`timescale 1ns/1ps
`include "mapper_config.svh"

module sys_mapper (
    input  logic                      clk,
    input  logic                      rst,
    // main CPU
    input  logic [23:1]               addr,
    input  logic [15:0]               cpu_dout,
    input  logic [1:0]                cpu_dsn,
    input  logic                      cpu_asn,
    input  logic                      cpu_rnw,
    input  logic [2:0]                cpu_fc,
    input  logic                      cpu_bgn,
    output logic                      cpu_dtackn,
    output logic                      cpu_brn,
    output logic                      cpu_bgackn,
    output logic [2:0]                cpu_ipln,
    output logic                      cpu_cen,
    // board bus
    input  logic [15:0]               bus_dout,
    input  logic                      bus_cs,
    input  logic                      bus_busy,
    output logic [23:1]               addr_out,
    output logic [15:0]               bus_din,
    output logic                      bus_asn,
    output logic [1:0]                bus_dsn,
    output logic                      bus_rnw,
    output logic [`MAP_NREGIONS-1:0]  active,
    output logic                      none,
    output logic [15:0]               mapper_dout,
    // sound CPU
    input  logic                      sndmap_rd,
    output logic [7:0]                sndmap_dout,
    output logic                      sndmap_pbf
);

    logic [16*`MAP_NREGIONS-1:0] region_cfg;
    logic [23:1]                 rd_addr;
    logic [23:1]                 wr_addr;
    logic [15:0]                 wr_data;
    logic                        xfer_start;
    logic                        xfer_busy;
    logic                        rd_done;
    logic                        int_ack;
    mapper_pkg::xfer_cmd_e       xfer_cmd;
    mapper_pkg::dtack_wait_e     dtack_wait;

    region_decode u_decode (
        .addr_out   (addr_out[23:16]),
        .cpu_fc     (cpu_fc),
        .cpu_asn    (cpu_asn),
        .region_cfg (region_cfg),
        .active     (active),
        .none       (none),
        .int_ack    (int_ack),
        .dtack_wait (dtack_wait)
    );

    dtack_gen u_dtack (
        .clk        (clk),
        .rst        (rst),
        .cpu_asn    (cpu_asn),
        .bus_busy   (bus_busy),
        .none       (none | ~bus_cs),   // deselected board takes the short wait
        .dtack_wait (dtack_wait),
        .cpu_cen    (cpu_cen),
        .cpu_dtackn (cpu_dtackn)
    );

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr[5:1]),
        .cpu_dout    (cpu_dout[7:0]),
        .cpu_dsn     (cpu_dsn[0]),
        .cpu_asn     (cpu_asn),
        .cpu_rnw     (cpu_rnw),
        .none        (none),
        .int_ack     (int_ack),
        .sndmap_rd   (sndmap_rd),
        .xfer_busy   (xfer_busy),
        .rd_done     (rd_done),
        .bus_dout    (bus_dout),
        .region_cfg  (region_cfg),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .xfer_start  (xfer_start),
        .xfer_cmd    (xfer_cmd),
        .cpu_ipln    (cpu_ipln),
        .sndmap_dout (sndmap_dout),
        .sndmap_pbf  (sndmap_pbf),
        .mapper_dout (mapper_dout)
    );

    bus_xfer u_xfer (
        .clk        (clk),
        .rst        (rst),
        .cpu_cen    (cpu_cen),
        .xfer_start (xfer_start),
        .xfer_cmd   (xfer_cmd),
        .rd_addr    (rd_addr),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .addr       (addr),
        .cpu_dout   (cpu_dout),
        .cpu_dsn    (cpu_dsn),
        .cpu_asn    (cpu_asn),
        .cpu_rnw    (cpu_rnw),
        .cpu_bgn    (cpu_bgn),
        .bus_busy   (bus_busy),
        .cpu_brn    (cpu_brn),
        .cpu_bgackn (cpu_bgackn),
        .addr_out   (addr_out),
        .bus_din    (bus_din),
        .bus_asn    (bus_asn),
        .bus_dsn    (bus_dsn),
        .bus_rnw    (bus_rnw),
        .xfer_busy  (xfer_busy),
        .rd_done    (rd_done)
    );

endmodule

/* files.f */
+incdir+design
+incdir+tb
design/mapper_pkg.sv
design/dtack_gen.sv
design/region_decode.sv
design/mapper_regs.sv
design/bus_xfer.sv
design/sys_mapper.sv
tb/tb_mapper.sv

/* run.sh */
#!/bin/sh
# build the mapper testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mapper \
    -f files.f -o tb_mapper
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mapper > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
echo "pass message missing from sim.log"
exit 1

/* tb/mapper_model.svh */
// reference model of the mapper registers, region table, DTACK waits and board memory
`ifndef MAPPER_MODEL_SVH
`define MAPPER_MODEL_SVH

logic [7:0]  model_regs [`MAP_NREGS];
logic [15:0] board_mem [logic [23:1]];   // words written by mapper transfers
logic [31:0] rnd_state = 32'd48;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic logic [31:0] rnd();
    rnd_state = lcg_step(rnd_state);
    return {rnd_state[15:0], rnd_state[31:16]};   // low lcg bits repeat quickly
endfunction

task automatic model_reset();
    for (int i = 0; i < `MAP_NREGS; i++) begin
        model_regs[i] = 8'h00;
    end
    model_regs[4] = 8'h07;
    board_mem.delete();
endtask

// index of the region that claims this top byte, -1 if none
function automatic int model_region(input logic [7:0] top, input logic [2:0] fc);
    int         nbits;
    logic [7:0] base;
    if (fc == 3'd7) return -1;   // interrupt acknowledge selects nothing
    for (int i = 0; i < `MAP_NREGIONS; i++) begin
        base = model_regs[17 + 2*i];
        case (model_regs[16 + 2*i][1:0])
            2'd0:    nbits = 8;   // 64 kB
            2'd1:    nbits = 7;
            2'd2:    nbits = 5;
            default: nbits = 3;   // 2 MB
        endcase
        if ((top >> (8 - nbits)) == (base >> (8 - nbits))) return i;
    end
    return -1;
endfunction

function automatic mapper_pkg::dtack_wait_e model_mode(input int r);
    if (r < 0) return mapper_pkg::WAIT_1;
    return mapper_pkg::dtack_wait_e'(model_regs[16 + 2*r][3:2]);
endfunction

function automatic int wait_steps(input mapper_pkg::dtack_wait_e mode, input logic short_path);
    if (short_path) return 1;
    case (mode)
        mapper_pkg::WAIT_2: return 2;
        mapper_pkg::WAIT_3: return 3;
        default:            return 1;   // bus wait only counts idle-bus pulses
    endcase
endfunction

function automatic logic [15:0] mem_read(input logic [23:1] a);
    if (board_mem.exists(a)) return board_mem[a];
    return a[16:1] ^ {9'd0, a[23:17]};   // fill pattern over the whole address
endfunction

function automatic void mem_write(input logic [23:1] a, input logic [15:0] d);
    board_mem[a] = d;
endfunction

`endif

/* tb/tb_mapper.sv */
// memory mapper testbench with random CPU accesses checked against a reference model
`timescale 1ns/1ps
`include "mapper_config.svh"

module tb_mapper;

    localparam int TMO = 200;   // clk cycles allowed for any single wait

    logic                      clk = 1'b0;
    logic                      rst;
    logic [23:1]               addr;
    logic [15:0]               cpu_dout;
    logic [1:0]                cpu_dsn;
    logic                      cpu_asn;
    logic                      cpu_rnw;
    logic [2:0]                cpu_fc;
    logic                      cpu_bgn;
    logic                      cpu_dtackn;
    logic                      cpu_brn;
    logic                      cpu_bgackn;
    logic [2:0]                cpu_ipln;
    logic                      cpu_cen;
    logic [15:0]               bus_dout = 16'h0000;
    logic                      bus_cs;
    logic                      bus_busy = 1'b0;
    logic [23:1]               addr_out;
    logic [15:0]               bus_din;
    logic                      bus_asn;
    logic [1:0]                bus_dsn;
    logic                      bus_rnw;
    logic [`MAP_NREGIONS-1:0]  active;
    logic                      none;
    logic [15:0]               mapper_dout;
    logic                      sndmap_rd;
    logic [7:0]                sndmap_dout;
    logic                      sndmap_pbf;
    logic                      busy_noise = 1'b0;
    logic [31:0]               busy_state = 32'd48;

    `include "mapper_model.svh"

    sys_mapper UUT (.*);

    always #50 clk = ~clk;

    // board side drives random busy and answers reads from memory
    always @(posedge clk) begin
        #1;
        busy_state = lcg_step(busy_state);
        bus_busy   = busy_noise && busy_state[29:28] == 2'b00;
        if (!bus_asn && bus_rnw) bus_dout = mem_read(addr_out);
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) fail_stop($sformatf("** Error %s expected %0h got %0h", name, exp, got));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) fail_stop($sformatf("** Error %s expected %02h got %02h", name, exp, got));
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) fail_stop($sformatf("** Error %s expected %04h got %04h", name, exp, got));
    endtask

    task automatic check_addr(input string name, input logic [23:1] exp, input logic [23:1] got);
        if (got !== exp) fail_stop($sformatf("** Error %s expected %06h got %06h", name, exp, got));
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) fail_stop($sformatf("** Error %s expected %0h got %0h", name, exp, got));
    endtask

    task automatic check_active(input logic [`MAP_NREGIONS-1:0] exp_act, input logic exp_none,
                                input logic [`MAP_NREGIONS-1:0] got_act, input logic got_none);
        if (got_act !== exp_act)
            fail_stop($sformatf("** Error active expected %02h got %02h", exp_act, got_act));
        check_bit("none", exp_none, got_none);
    endtask

    task automatic check_wait(input mapper_pkg::dtack_wait_e mode, input logic short_path,
                              input int got);
        int exp;
        exp = wait_steps(mode, short_path);
        if (got != exp)
            fail_stop($sformatf("** Error cpu_cen count (%s) expected %0h got %0h",
                                mode.name(), exp, got));
    endtask

    function automatic logic probe(input string name);
        if (name == "cpu_brn") return cpu_brn;
        if (name == "cpu_bgackn") return cpu_bgackn;
        if (name == "bus_asn") return bus_asn;
        return cpu_dtackn;
    endfunction

    task automatic wait_signal(input string name, input logic level);
        int n;
        n = 0;
        while (probe(name) !== level && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (probe(name) !== level)
            fail_stop($sformatf("timeout waiting for %s to reach %0d", name, level));
    endtask

    // cpu_cen pulses for one clk every MAP_CEN_DIV cycles
    task automatic cen_period();
        int n;
        n = 0;
        while (!cpu_cen && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_cen) fail_stop("timeout waiting for cpu_cen to pulse");
        for (int p = 0; p < 4; p++) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!cpu_cen && n < TMO);
            check_count("cpu_cen period", `MAP_CEN_DIV, n);
        end
    endtask

    // one-clk read strobe from the sound CPU
    task automatic sound_read();
        @(posedge clk);
        #1;
        sndmap_rd = 1'b1;
        @(posedge clk);
        #1;
        sndmap_rd = 1'b0;
    endtask

    // one 68000 bus cycle counting the idle-bus cen pulses until DTACK
    task automatic cpu_cycle(input logic [23:1] a, input logic [15:0] d, input logic rnw,
                             input logic [2:0] fc, input logic cs, output int cens,
                             output logic [`MAP_NREGIONS-1:0] act, output logic nn);
        int n;
        @(posedge clk);
        #1;
        addr     = a;
        cpu_dout = d;
        cpu_rnw  = rnw;
        cpu_fc   = fc;
        bus_cs   = cs;
        cpu_dsn  = 2'b00;
        cpu_asn  = 1'b0;
        cens     = 0;
        n        = 0;
        @(negedge clk);
        act = active;
        nn  = none;
        while (cpu_dtackn && n < TMO) begin
            if (cpu_cen && !bus_busy) cens++;
            @(negedge clk);
            n++;
        end
        if (cpu_dtackn) fail_stop("timeout waiting for cpu_dtackn to fall");
        @(posedge clk);
        #1;
        cpu_asn = 1'b1;
        cpu_dsn = 2'b11;
        cpu_rnw = 1'b1;
        wait_signal("cpu_dtackn", 1'b1);
    endtask

    task automatic bus_access(input logic [23:1] a, input logic [15:0] d, input logic rnw,
                              input logic [2:0] fc, input logic cs);
        int                       cens;
        int                       r;
        logic [`MAP_NREGIONS-1:0] act;
        logic                     nn;
        r = model_region(a[23:16], fc);
        cpu_cycle(a, d, rnw, fc, cs, cens, act, nn);
        check_active(r < 0 ? '0 : `MAP_NREGIONS'(1 << r), r < 0 && fc != 3'd7, act, nn);
        check_wait(model_mode(r), r < 0 || !cs, cens);
        if (fc == 3'd7) model_regs[4] = 8'h07;   // acknowledge clears the level
        else if (r < 0 && !rnw) model_regs[a[5:1]] = d[7:0];
    endtask

    // bit 23 set keeps register accesses clear of every configured region
    task automatic reg_write(input logic [4:0] idx, input logic [7:0] val);
        logic [31:0] r;
        r = rnd();
        bus_access({1'b1, r[16:0], idx}, {r[31:24], val}, 1'b0, 3'd5, 1'b1);
    endtask

    task automatic mapper_transfer(input logic rd, input logic [23:1] a, input logic [15:0] d);
        int          held;
        logic [15:0] word;
        if (rd) begin
            reg_write(mapper_pkg::REG_RD_ADDR_H, {1'b0, a[23:17]});
            reg_write(mapper_pkg::REG_RD_ADDR_M, a[16:9]);
            reg_write(mapper_pkg::REG_RD_ADDR_L, a[8:1]);
        end else begin
            reg_write(mapper_pkg::REG_WR_ADDR_H, {1'b0, a[23:17]});
            reg_write(mapper_pkg::REG_WR_ADDR_M, a[16:9]);
            reg_write(mapper_pkg::REG_WR_ADDR_L, a[8:1]);
            reg_write(mapper_pkg::REG_DATA_HI, d[15:8]);
            reg_write(mapper_pkg::REG_DATA_LO, d[7:0]);
        end
        reg_write(mapper_pkg::REG_XFER_CMD,
                  rd ? 8'(mapper_pkg::XFER_READ) : 8'(mapper_pkg::XFER_WRITE));
        wait_signal("cpu_brn", 1'b0);
        check_bit("cpu_bgackn", 1'b1, cpu_bgackn);   // no ack before the grant
        @(posedge clk);
        #1;
        cpu_bgn = 1'b0;
        wait_signal("cpu_bgackn", 1'b0);
        check_bit("cpu_brn", 1'b1, cpu_brn);
        @(posedge clk);
        #1;
        cpu_bgn = 1'b1;
        wait_signal("bus_asn", 1'b0);
        held = 0;
        while (!bus_asn && held < TMO) begin
            check_addr("addr_out", a, addr_out);
            check_bit("bus_rnw", rd, bus_rnw);
            check_byte("bus_dsn", 8'h00, {6'd0, bus_dsn});
            if (!rd) check_word("bus_din", {model_regs[0], model_regs[1]}, bus_din);
            @(negedge clk);
            held++;
        end
        if (!bus_asn) fail_stop("timeout while the mapper held the board bus");
        if (held < `MAP_XFER_HOLD)
            fail_stop($sformatf("bus_asn was low for only %0d cycles", held));
        wait_signal("cpu_bgackn", 1'b1);
        if (rd) begin
            word          = mem_read(a);
            model_regs[0] = word[15:8];
            model_regs[1] = word[7:0];
            check_word("mapper_dout", word, mapper_dout);
        end else begin
            mem_write(a, d);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [7:0]  top;
        logic [4:0]  plain_regs [8];
        plain_regs = '{5'd0, 5'd1, 5'd3, 5'd4, 5'd7, 5'd9, 5'd11, 5'd12};
        rst       = 1'b1;
        addr      = '0;
        cpu_dout  = 16'h0000;
        cpu_dsn   = 2'b11;
        cpu_asn   = 1'b1;
        cpu_rnw   = 1'b1;
        cpu_fc    = 3'd5;
        cpu_bgn   = 1'b1;
        bus_cs    = 1'b1;
        sndmap_rd = 1'b0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("cpu_dtackn", 1'b1, cpu_dtackn);
        check_bit("cpu_brn", 1'b1, cpu_brn);
        check_bit("cpu_bgackn", 1'b1, cpu_bgackn);
        check_bit("bus_asn", 1'b1, bus_asn);
        check_bit("sndmap_pbf", 1'b0, sndmap_pbf);
        check_byte("cpu_ipln", 8'h07, {5'd0, cpu_ipln});
        cen_period();

        // plain register writes read back on the outputs
        for (int i = 0; i < 40; i++) begin
            r = rnd();
            reg_write(plain_regs[r[2:0]], r[15:8]);
            check_word("mapper_dout", {model_regs[0], model_regs[1]}, mapper_dout);
            check_byte("sndmap_dout", model_regs[3], sndmap_dout);
            check_byte("cpu_ipln", {5'd0, model_regs[4][2:0]}, {5'd0, cpu_ipln});
        end

        // region decode and DTACK waits with a busy board on odd rounds
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < `MAP_NREGIONS; k++) begin
                r = rnd();
                reg_write(5'(16 + 2*k), {4'h0, r[3:0]});
                reg_write(5'(17 + 2*k), {1'b0, r[14:8]});
            end
            busy_noise = round[0];
            for (int j = 0; j < 25; j++) begin
                r   = rnd();
                r2  = rnd();
                top = r[24] ? r[23:16] : model_regs[17 + 2*r[2:0]] ^ {5'd0, r[5:3]};
                bus_access({top, r2[14:0]}, 16'h0000, 1'b1, 3'd5, r[27:26] != 2'b00);
            end
        end
        busy_noise = 1'b0;

        // sound latch flag, cleared first so the write has to set it
        sound_read();
        check_bit("sndmap_pbf", 1'b0, sndmap_pbf);
        r = rnd();
        reg_write(mapper_pkg::REG_SND_LATCH, r[7:0]);
        check_bit("sndmap_pbf", 1'b1, sndmap_pbf);
        check_byte("sndmap_dout", model_regs[3], sndmap_dout);
        sound_read();
        check_bit("sndmap_pbf", 1'b0, sndmap_pbf);

        // interrupt acknowledge masks the decode and resets the level
        reg_write(mapper_pkg::REG_IPL, {6'd0, r[9:8]});
        check_byte("cpu_ipln", {5'd0, model_regs[4][2:0]}, {5'd0, cpu_ipln});
        bus_access({model_regs[17], 15'h7ff8}, 16'h0000, 1'b1, 3'd7, 1'b1);   // hits region 0
        check_byte("cpu_ipln", {5'd0, model_regs[4][2:0]}, {5'd0, cpu_ipln});

        // mapper transfers that write, read back and then read untouched memory
        for (int t = 0; t < 4; t++) begin
            busy_noise = t[0];
            r  = rnd();
            r2 = rnd();
            mapper_transfer(1'b0, r[22:0], r2[15:0]);
            mapper_transfer(1'b1, r[22:0], 16'h0000);
            mapper_transfer(1'b1, r2[30:8], 16'h0000);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
